/* flist.f */
+incdir+common
common/decoder_pkg.sv
decode/decode_ctrl.sv
decode/imm_gen.sv
decode/alu_op_decode.sv
decode/mem_op_decode.sv
rtl/inst_decoder.sv
bench/tb_inst_decoder.sv

/* bench/tb_inst_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

`include "decoder_defs.svh"

module tb_inst_decoder;
    import decoder_pkg::*;

    localparam int NUM_WORDS   = 3000;
    localparam int WAIT_CYCLES = 8;

    logic        clock;
    logic        arst_n;
    logic        inst_valid;
    inst_t       inst;
    logic        dec_valid;
    logic        dec_illegal;
    reg_idx_t    rs1;
    reg_idx_t    rs2;
    reg_idx_t    rd;
    xlen_t       imm;
    alu_type_t   alu_type;
    cx_type_t    cx_type;
    ls_size_t    ls_size;
    logic        is_word;
    logic        is_imm;
    logic        is_load;
    logic        is_store;
    logic        is_unsigned;
    logic        need_to_wb;

    inst_t       last_word;   // Word behind the current result
    inst_class_e exp_class;
    xlen_t       exp_imm;
    alu_type_t   exp_alu;
    cx_type_t    exp_cx;
    ls_size_t    exp_size;
    logic        exp_word;
    logic        exp_imm_form;
    logic        exp_unsigned;
    logic        exp_wb;
    logic [31:0] lcg_state;
    int          errors;
    int          issued;
    int          results;

    inst_decoder inst_decoder_i (
        .clock       (clock),
        .arst_n      (arst_n),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .dec_valid   (dec_valid),
        .dec_illegal (dec_illegal),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .imm         (imm),
        .alu_type    (alu_type),
        .cx_type     (cx_type),
        .ls_size     (ls_size),
        .is_word     (is_word),
        .is_imm      (is_imm),
        .is_load     (is_load),
        .is_store    (is_store),
        .is_unsigned (is_unsigned),
        .need_to_wb  (need_to_wb)
    );

    always #5 clock = ~clock;

    always @(posedge clock) begin
        if (inst_valid) begin
            last_word <= inst;
            issued    <= issued + 1;
        end
        if (arst_n && dec_valid) begin
            results <= results + 1;
        end
    end

    //##########################################################################
    // Reference rules

    function automatic inst_class_e classify(input inst_t w);
        logic m_ext;
        m_ext = (w[31:25] == 7'b0000001);
        case (w[6:0])
            `OPC_LUI:       return CLS_LUI;
            `OPC_AUIPC:     return CLS_AUIPC;
            `OPC_JAL:       return CLS_JAL;
            `OPC_JALR:      return CLS_JALR;
            `OPC_BRANCH:    return CLS_BRANCH;
            `OPC_LOAD:      return CLS_LOAD;
            `OPC_STORE:     return CLS_STORE;
            `OPC_OP_IMM:    return CLS_OP_IMM;
            `OPC_OP_IMM_32: return CLS_OP_IMM_32;
            `OPC_OP:        return m_ext ? CLS_ILLEGAL : CLS_OP;
            `OPC_OP_32:     return m_ext ? CLS_ILLEGAL : CLS_OP_32;
            default:        return CLS_ILLEGAL;
        endcase
    endfunction

    // Field packed at the top, then shifted down arithmetically
    function automatic xlen_t expected_imm(input inst_t w, input inst_class_e c);
        logic signed [63:0] v;
        case (c)
            CLS_JALR, CLS_LOAD, CLS_OP_IMM, CLS_OP_IMM_32: begin
                v = {w[31:20], 52'b0};
                return v >>> 52;
            end
            CLS_STORE: begin
                v = {w[31:25], w[11:7], 52'b0};
                return v >>> 52;
            end
            CLS_BRANCH: begin
                v = {w[31], w[7], w[30:25], w[11:8], 1'b0, 51'b0};
                return v >>> 51;
            end
            CLS_LUI, CLS_AUIPC: begin
                v = {w[31:12], 12'b0, 32'b0};
                return v >>> 32;
            end
            CLS_JAL: begin
                v = {w[31], w[19:12], w[20], w[30:21], 1'b0, 43'b0};
                return v >>> 43;
            end
            default: return '0;
        endcase
    endfunction

    // ALU bit for the four OP classes or -1 for an unlisted encoding
    function automatic int alu_index(input inst_t w, input inst_class_e c);
        logic [2:0] f3;
        logic       word;
        logic       imm_form;
        logic       base;
        logic       alt;
        f3       = w[14:12];
        word     = (c == CLS_OP_32) || (c == CLS_OP_IMM_32);
        imm_form = (c == CLS_OP_IMM) || (c == CLS_OP_IMM_32);
        // funct7[0] is shamt[5] in OP_IMM
        base = (c == CLS_OP_IMM) ? (w[31:26] == 6'b000000) : (w[31:25] == 7'b0000000);
        alt  = (c == CLS_OP_IMM) ? (w[31:26] == 6'b010000) : (w[31:25] == 7'b0100000);
        case (f3)
            3'b000: begin
                if (imm_form || base)
                    return `IS_ADD;
                if (alt)
                    return `IS_SUB;
            end
            3'b001: if (base) return `IS_SLL;
            3'b101: begin
                if (base)
                    return `IS_SRL;
                if (alt)
                    return `IS_SRA;
            end
            3'b010, 3'b011: if (!word && (imm_form || base)) return `IS_SLT;
            3'b100: if (!word && (imm_form || base)) return `IS_XOR;
            3'b110: if (!word && (imm_form || base)) return `IS_OR;
            3'b111: if (!word && (imm_form || base)) return `IS_AND;
            default: ;
        endcase
        return -1;
    endfunction

    always_comb begin : reference_model
        logic [2:0] f3;
        int         idx;
        f3           = last_word[14:12];
        idx          = -1;
        exp_class    = classify(last_word);
        exp_imm      = expected_imm(last_word, exp_class);
        exp_alu      = '0;
        exp_cx       = '0;
        exp_size     = '0;
        exp_word     = 1'b0;
        exp_imm_form = 1'b0;
        exp_unsigned = 1'b0;
        exp_wb       = !(exp_class inside {CLS_BRANCH, CLS_STORE, CLS_ILLEGAL});
        case (exp_class)
            CLS_LUI:   exp_alu[`IS_LUI]   = 1'b1;
            CLS_AUIPC: exp_alu[`IS_AUIPC] = 1'b1;
            CLS_JAL:   exp_cx[`IS_JAL]    = 1'b1;
            CLS_JALR:  exp_cx[`IS_JALR]   = 1'b1;
            CLS_BRANCH: begin
                case (f3)
                    3'b000:         exp_cx[`IS_BEQ] = 1'b1;
                    3'b001:         exp_cx[`IS_BNE] = 1'b1;
                    3'b100, 3'b110: exp_cx[`IS_BLT] = 1'b1;
                    3'b101, 3'b111: exp_cx[`IS_BGE] = 1'b1;
                    default: ;
                endcase
                exp_unsigned = (f3 == 3'b110) || (f3 == 3'b111);
            end
            CLS_LOAD, CLS_STORE: begin
                if ((exp_class == CLS_LOAD && f3 != 3'b111) ||
                    (exp_class == CLS_STORE && !f3[2])) begin
                    case (f3[1:0])
                        2'b00: exp_size[`IS_B] = 1'b1;
                        2'b01: exp_size[`IS_H] = 1'b1;
                        2'b10: exp_size[`IS_W] = 1'b1;
                        2'b11: exp_size[`IS_D] = 1'b1;
                    endcase
                end
                exp_unsigned = (exp_class == CLS_LOAD) && f3 inside {3'b100, 3'b101, 3'b110};
            end
            CLS_OP, CLS_OP_32, CLS_OP_IMM, CLS_OP_IMM_32: begin
                idx = alu_index(last_word, exp_class);
                if (idx >= 0) begin
                    exp_alu[idx] = 1'b1;
                    exp_word     = exp_class inside {CLS_OP_32, CLS_OP_IMM_32};
                    exp_imm_form = exp_class inside {CLS_OP_IMM, CLS_OP_IMM_32};
                end
                if (f3 == 3'b011)  // SLTIU, SLTU
                    exp_unsigned = (exp_class == CLS_OP_IMM) ||
                                   (exp_class == CLS_OP && last_word[31:25] == 7'b0);
            end
            default: ;
        endcase
    end

    //##########################################################################
    // Checks

    task automatic flag_error(input string msg);
        errors++;
        $display("ERROR %0t: %s", $time, msg);
    endtask

    a_reset_quiet: assert property (@(posedge clock) !arst_n |-> !dec_valid)
        else flag_error("dec_valid set during reset");
    a_strobe_follows: assert property (@(posedge clock) disable iff (!arst_n)
        inst_valid |=> dec_valid) else flag_error("dec_valid missing after strobe");
    a_no_extra: assert property (@(posedge clock) disable iff (!arst_n)
        !inst_valid |=> !dec_valid) else flag_error("dec_valid without strobe");
    a_fields: assert property (@(posedge clock) disable iff (!arst_n) dec_valid |->
        (rs1 == last_word[19:15] && rs2 == last_word[24:20] && rd == last_word[11:7]))
        else flag_error($sformatf("register index mismatch for %h", last_word));
    a_imm: assert property (@(posedge clock) disable iff (!arst_n)
        dec_valid |-> imm == exp_imm)
        else flag_error($sformatf("imm %h, expected %h for %h", imm, exp_imm, last_word));
    a_alu: assert property (@(posedge clock) disable iff (!arst_n) dec_valid |->
        (alu_type == exp_alu && is_word == exp_word && is_imm == exp_imm_form))
        else flag_error($sformatf("ALU decode %h wrong for %h", alu_type, last_word));
    a_mem: assert property (@(posedge clock) disable iff (!arst_n) dec_valid |->
        (ls_size == exp_size && is_load == (exp_class == CLS_LOAD) &&
         is_store == (exp_class == CLS_STORE)))
        else flag_error($sformatf("memory decode wrong for %h", last_word));
    a_ctrl: assert property (@(posedge clock) disable iff (!arst_n) dec_valid |->
        (cx_type == exp_cx && is_unsigned == exp_unsigned && need_to_wb == exp_wb &&
         dec_illegal == (exp_class == CLS_ILLEGAL)))
        else flag_error($sformatf("control decode wrong for %h", last_word));

    //##########################################################################
    // Stimulus

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic inst_t make_word();
        inst_t       w;
        logic [31:0] r;
        w = lcg_next();
        r = lcg_next();
        case (r[31:28])
            4'd0:        w[6:0] = `OPC_LUI;
            4'd1:        w[6:0] = `OPC_AUIPC;
            4'd2:        w[6:0] = `OPC_JAL;
            4'd3:        w[6:0] = `OPC_JALR;
            4'd4:        w[6:0] = `OPC_BRANCH;
            4'd5:        w[6:0] = `OPC_LOAD;
            4'd6:        w[6:0] = `OPC_STORE;
            4'd7:        w[6:0] = `OPC_OP_IMM;
            4'd8:        w[6:0] = `OPC_OP_IMM_32;
            4'd9, 4'd14: w[6:0] = `OPC_OP;
            4'd10, 4'd15: w[6:0] = `OPC_OP_32;
            4'd11:       w[6:0] = 7'b0001111;     // FENCE
            4'd12:       w[6:0] = 7'b1110011;     // SYSTEM
            default:     w[1:0] = 2'b10;          // No 32-bit opcode here
        endcase
        // Base, alternate and M-extension funct7 more often than chance
        case (r[27:26])
            2'd0:    w[31:25] = 7'b0000000;
            2'd1:    w[31:25] = 7'b0100000;
            2'd2:    w[31:25] = 7'b0000001;
            default: ;
        endcase
        if (w[6:0] == `OPC_OP_IMM)
            w[25] = r[25];
        return w;
    endfunction

    task automatic wait_for_result();
        int n;
        n = 0;
        while (!dec_valid && n < WAIT_CYCLES) begin
            @(negedge clock);
            n++;
        end
        if (!dec_valid) begin
            $display("Timeout: no dec_valid within %0d cycles of a strobe", WAIT_CYCLES);
            $display("Some tests failed");
            $finish;
        end
    endtask

    initial begin
        int    run;
        int    gap;
        int    sent;
        logic [31:0] r;
        lcg_state  = 32'h8b82f5f5;
        errors     = 0;
        issued     = 0;
        results    = 0;
        sent       = 0;
        clock      = 1'b0;
        arst_n     = 1'b1;
        inst_valid = 1'b0;
        inst       = '0;
        #1;
        arst_n = 1'b0;  // Clean falling edge into reset
        repeat (16) @(posedge clock);
        @(negedge clock);
        arst_n = 1'b1;
        @(negedge clock);
        a_reset_state: assert (dec_illegal && !dec_valid && imm == '0 && alu_type == '0 &&
                               cx_type == '0 && ls_size == '0 && !need_to_wb &&
                               !is_word && !is_imm && !is_load && !is_store && !is_unsigned)
            else flag_error("outputs not idle after reset");

        while (sent < NUM_WORDS) begin
            r   = lcg_next();
            run = 1 + r[31:30];   // Back-to-back runs of 1 to 4
            gap = r[29:28] % 3;
            repeat (run) begin
                inst_valid = 1'b1;
                inst       = make_word();
                sent++;
                @(negedge clock);
            end
            inst_valid = 1'b0;
            inst       = lcg_next();
            wait_for_result();
            repeat (gap) @(negedge clock);
        end
        repeat (3) @(negedge clock);

        a_all_returned: assert (results == issued)
            else flag_error($sformatf("%0d results for %0d strobes", results, issued));
        $display("Strobes: %0d, results: %0d, errors: %0d", issued, results, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

    // Hard limit on the whole run
    initial begin
        #(NUM_WORDS * 100);
        $display("Timeout: simulation did not finish in time");
        $display("Some tests failed");
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/inst_decoder.sv */
`timescale 1ns/100ps
`default_nettype none

module inst_decoder (
    input  logic                  clock,
    input  logic                  arst_n,
    input  logic                  inst_valid,
    input  decoder_pkg::inst_t    inst,
    output logic                  dec_valid,
    output logic                  dec_illegal,
    output decoder_pkg::reg_idx_t rs1,
    output decoder_pkg::reg_idx_t rs2,
    output decoder_pkg::reg_idx_t rd,
    output decoder_pkg::xlen_t    imm,
    output decoder_pkg::alu_type_t alu_type,
    output decoder_pkg::cx_type_t cx_type,
    output decoder_pkg::ls_size_t ls_size,
    output logic                  is_word,
    output logic                  is_imm,
    output logic                  is_load,
    output logic                  is_store,
    output logic                  is_unsigned,
    output logic                  need_to_wb
);
    import decoder_pkg::*;

    inst_t       stage_inst;
    inst_class_e stage_class;

    // Stage register and control decode
    decode_ctrl decode_ctrl_i (
        .clock       (clock),
        .arst_n      (arst_n),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .stage_inst  (stage_inst),
        .stage_class (stage_class),
        .dec_valid   (dec_valid),
        .dec_illegal (dec_illegal),
        .rs1         (rs1),
        .rs2         (rs2),
        .rd          (rd),
        .cx_type     (cx_type),
        .is_unsigned (is_unsigned),
        .need_to_wb  (need_to_wb)
    );

    imm_gen imm_gen_i (
        .stage_inst  (stage_inst),
        .stage_class (stage_class),
        .imm         (imm)
    );

    alu_op_decode alu_op_decode_i (
        .stage_inst  (stage_inst),
        .stage_class (stage_class),
        .alu_type    (alu_type),
        .is_word     (is_word),
        .is_imm      (is_imm)
    );

    mem_op_decode mem_op_decode_i (
        .stage_inst  (stage_inst),
        .stage_class (stage_class),
        .is_load     (is_load),
        .is_store    (is_store),
        .ls_size     (ls_size)
    );

endmodule

`default_nettype wire

/* decode/mem_op_decode.sv */
`timescale 1ns/100ps
`default_nettype none

`include "decoder_defs.svh"

module mem_op_decode (
    input  decoder_pkg::inst_t       stage_inst,
    input  decoder_pkg::inst_class_e stage_class,
    output logic                     is_load,
    output logic                     is_store,
    output decoder_pkg::ls_size_t    ls_size
);
    import decoder_pkg::*;

    logic [2:0] funct3;
    logic       size_ok;

    assign funct3   = stage_inst[14:12];
    assign is_load  = (stage_class == CLS_LOAD);
    assign is_store = (stage_class == CLS_STORE);

    // No LDU, and stores have no unsigned forms
    assign size_ok = (is_load && (funct3 != 3'b111)) || (is_store && !funct3[2]);

    always_comb begin
        ls_size = '0;
        if (size_ok) begin
            case (funct3[1:0])
                2'b00: ls_size[`IS_B] = 1'b1;
                2'b01: ls_size[`IS_H] = 1'b1;
                2'b10: ls_size[`IS_W] = 1'b1;
                2'b11: ls_size[`IS_D] = 1'b1;
            endcase
        end
    end

    always_comb begin
        a_ls_excl: assert final (!(is_load && is_store))
            else $error("load and store both set");
        a_ls_onehot: assert final ($onehot0(ls_size))
            else $error("ls_size is not one-hot");
    end

endmodule

`default_nettype wire

/* decode/alu_op_decode.sv */
`timescale 1ns/100ps
`default_nettype none

`include "decoder_defs.svh"

module alu_op_decode (
    input  decoder_pkg::inst_t       stage_inst,
    input  decoder_pkg::inst_class_e stage_class,
    output decoder_pkg::alu_type_t   alu_type,
    output logic                     is_word,
    output logic                     is_imm
);
    import decoder_pkg::*;

    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       hit;

    assign funct3 = stage_inst[14:12];
    assign funct7 = stage_inst[31:25];

    always_comb begin
        alu_type = '0;
        case (stage_class)
            CLS_LUI:   alu_type[`IS_LUI]   = 1'b1;
            CLS_AUIPC: alu_type[`IS_AUIPC] = 1'b1;
            CLS_OP_IMM: begin
                // Shamt is 6 bits on RV64, so only funct7[6:1] selects
                casez ({funct7[6:1], funct3})
                    9'b??????000: alu_type[`IS_ADD] = 1'b1;
                    9'b??????010,
                    9'b??????011: alu_type[`IS_SLT] = 1'b1;
                    9'b??????100: alu_type[`IS_XOR] = 1'b1;
                    9'b??????110: alu_type[`IS_OR]  = 1'b1;
                    9'b??????111: alu_type[`IS_AND] = 1'b1;
                    9'b000000001: alu_type[`IS_SLL] = 1'b1;
                    9'b000000101: alu_type[`IS_SRL] = 1'b1;
                    9'b010000101: alu_type[`IS_SRA] = 1'b1;
                    default: ;
                endcase
            end
            CLS_OP: begin
                case ({funct7, funct3})
                    10'b0000000_000: alu_type[`IS_ADD] = 1'b1;
                    10'b0100000_000: alu_type[`IS_SUB] = 1'b1;
                    10'b0000000_001: alu_type[`IS_SLL] = 1'b1;
                    10'b0000000_010,
                    10'b0000000_011: alu_type[`IS_SLT] = 1'b1;
                    10'b0000000_100: alu_type[`IS_XOR] = 1'b1;
                    10'b0000000_101: alu_type[`IS_SRL] = 1'b1;
                    10'b0100000_101: alu_type[`IS_SRA] = 1'b1;
                    10'b0000000_110: alu_type[`IS_OR]  = 1'b1;
                    10'b0000000_111: alu_type[`IS_AND] = 1'b1;
                    default: ;
                endcase
            end
            CLS_OP_IMM_32: begin
                casez ({funct7, funct3})
                    10'b???????_000: alu_type[`IS_ADD] = 1'b1;  // ADDIW
                    10'b0000000_001: alu_type[`IS_SLL] = 1'b1;
                    10'b0000000_101: alu_type[`IS_SRL] = 1'b1;
                    10'b0100000_101: alu_type[`IS_SRA] = 1'b1;
                    default: ;
                endcase
            end
            CLS_OP_32: begin
                case ({funct7, funct3})
                    10'b0000000_000: alu_type[`IS_ADD] = 1'b1;
                    10'b0100000_000: alu_type[`IS_SUB] = 1'b1;
                    10'b0000000_001: alu_type[`IS_SLL] = 1'b1;
                    10'b0000000_101: alu_type[`IS_SRL] = 1'b1;
                    10'b0100000_101: alu_type[`IS_SRA] = 1'b1;
                    default: ;
                endcase
            end
            default: ;
        endcase
    end

    // Flags only for a listed encoding
    assign hit     = |alu_type;
    assign is_word = hit && (stage_class inside {CLS_OP_32, CLS_OP_IMM_32});
    assign is_imm  = hit && (stage_class inside {CLS_OP_IMM, CLS_OP_IMM_32});

    always_comb begin
        a_alu_onehot: assert final ($onehot0(alu_type))
            else $error("alu_type is not one-hot");
    end

endmodule

`default_nettype wire

/* decode/imm_gen.sv */
`timescale 1ns/100ps
`default_nettype none

`include "decoder_defs.svh"

module imm_gen (
    input  decoder_pkg::inst_t       stage_inst,
    input  decoder_pkg::inst_class_e stage_class,
    output decoder_pkg::xlen_t       imm
);
    import decoder_pkg::*;

    logic  sign;
    xlen_t imm_i;
    xlen_t imm_s;
    xlen_t imm_b;
    xlen_t imm_u;
    xlen_t imm_j;

    assign sign = stage_inst[31];

    // Every format extends from inst[31]
    assign imm_i = {{(`XLEN-12){sign}}, stage_inst[31:20]};
    assign imm_s = {{(`XLEN-12){sign}}, stage_inst[31:25], stage_inst[11:7]};
    assign imm_b = {{(`XLEN-12){sign}}, stage_inst[7], stage_inst[30:25],
                    stage_inst[11:8], 1'b0};
    assign imm_u = {{(`XLEN-32){sign}}, stage_inst[31:12], 12'b0};
    assign imm_j = {{(`XLEN-20){sign}}, stage_inst[19:12], stage_inst[20],
                    stage_inst[30:21], 1'b0};

    always_comb begin
        case (stage_class)
            CLS_JALR,
            CLS_LOAD,
            CLS_OP_IMM,
            CLS_OP_IMM_32: imm = imm_i;
            CLS_STORE:     imm = imm_s;
            CLS_BRANCH:    imm = imm_b;
            CLS_LUI,
            CLS_AUIPC:     imm = imm_u;
            CLS_JAL:       imm = imm_j;
            default:       imm = '0;  // R-type and illegal
        endcase
    end

endmodule

`default_nettype wire

/* decode/decode_ctrl.sv */
`timescale 1ns/100ps
`default_nettype none

`include "decoder_defs.svh"

module decode_ctrl (
    input  logic                     clock,
    input  logic                     arst_n,
    input  logic                     inst_valid,
    input  decoder_pkg::inst_t       inst,
    output decoder_pkg::inst_t       stage_inst,
    output decoder_pkg::inst_class_e stage_class,
    output logic                     dec_valid,
    output logic                     dec_illegal,
    output decoder_pkg::reg_idx_t    rs1,
    output decoder_pkg::reg_idx_t    rs2,
    output decoder_pkg::reg_idx_t    rd,
    output decoder_pkg::cx_type_t    cx_type,
    output logic                     is_unsigned,
    output logic                     need_to_wb
);
    import decoder_pkg::*;

    inst_class_e in_class;
    logic        is_muldiv;
    logic [2:0]  funct3;
    logic [6:0]  funct7;

    //##########################################################################
    // Classify the incoming word

    assign is_muldiv = (inst[31:25] == 7'b0000001);

    always_comb begin
        case (inst[6:0])
            `OPC_LUI:       in_class = CLS_LUI;
            `OPC_AUIPC:     in_class = CLS_AUIPC;
            `OPC_JAL:       in_class = CLS_JAL;
            `OPC_JALR:      in_class = CLS_JALR;
            `OPC_BRANCH:    in_class = CLS_BRANCH;
            `OPC_LOAD:      in_class = CLS_LOAD;
            `OPC_STORE:     in_class = CLS_STORE;
            `OPC_OP_IMM:    in_class = CLS_OP_IMM;
            `OPC_OP_IMM_32: in_class = CLS_OP_IMM_32;
            `OPC_OP:        in_class = is_muldiv ? CLS_ILLEGAL : CLS_OP;
            `OPC_OP_32:     in_class = is_muldiv ? CLS_ILLEGAL : CLS_OP_32;
            default:        in_class = CLS_ILLEGAL;  // FENCE, SYSTEM, unknown
        endcase
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            dec_valid   <= 1'b0;
            stage_class <= CLS_ILLEGAL;
        end else begin
            dec_valid <= inst_valid;
            if (inst_valid) begin
                stage_class <= in_class;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (inst_valid) begin
            stage_inst <= inst;
        end
    end

    //##########################################################################
    // Control decode of the staged word

    assign funct3      = stage_inst[14:12];
    assign funct7      = stage_inst[31:25];
    assign rs1         = stage_inst[19:15];
    assign rs2         = stage_inst[24:20];
    assign rd          = stage_inst[11:7];
    assign dec_illegal = (stage_class == CLS_ILLEGAL);

    always_comb begin
        cx_type     = '0;
        is_unsigned = 1'b0;
        need_to_wb  = 1'b1;
        case (stage_class)
            CLS_JAL:  cx_type[`IS_JAL]  = 1'b1;
            CLS_JALR: cx_type[`IS_JALR] = 1'b1;
            CLS_BRANCH: begin
                need_to_wb  = 1'b0;
                is_unsigned = (funct3[2:1] == 2'b11);  // BLTU, BGEU
                case (funct3)
                    3'b000:         cx_type[`IS_BEQ] = 1'b1;
                    3'b001:         cx_type[`IS_BNE] = 1'b1;
                    3'b100, 3'b110: cx_type[`IS_BLT] = 1'b1;
                    3'b101, 3'b111: cx_type[`IS_BGE] = 1'b1;
                    default: ;
                endcase
            end
            CLS_LOAD:    is_unsigned = funct3[2] && (funct3 != 3'b111);
            CLS_STORE:   need_to_wb  = 1'b0;
            CLS_OP_IMM:  is_unsigned = (funct3 == 3'b011);  // SLTIU
            CLS_OP:      is_unsigned = (funct3 == 3'b011) && (funct7 == 7'b0000000);
            CLS_ILLEGAL: need_to_wb  = 1'b0;
            default: ;
        endcase
    end

    a_dec_valid_known: assert property (
        @(posedge clock) disable iff (!arst_n) !$isunknown(dec_valid)
    ) else $error("dec_valid is unknown");

endmodule

`default_nettype wire

/* common/decoder_pkg.sv */
`default_nettype none

`include "decoder_defs.svh"

package decoder_pkg;

    typedef logic [`ILEN-1:0]       inst_t;
    typedef logic [`XLEN-1:0]       xlen_t;
    typedef logic [`REG_IDX_W-1:0]  reg_idx_t;

    // One-hot decode vectors
    typedef logic [`ALU_TYPE_W-1:0] alu_type_t;
    typedef logic [`CX_TYPE_W-1:0]  cx_type_t;
    typedef logic [`LS_SIZE_W-1:0]  ls_size_t;

    // Instruction class registered with the word
    typedef enum logic [3:0] {
        CLS_LUI,
        CLS_AUIPC,
        CLS_JAL,
        CLS_JALR,
        CLS_BRANCH,
        CLS_LOAD,
        CLS_STORE,
        CLS_OP_IMM,
        CLS_OP,
        CLS_OP_IMM_32,
        CLS_OP_32,
        CLS_ILLEGAL
    } inst_class_e;

endpackage

`default_nettype wire

/* common/decoder_defs.svh */
`ifndef DECODER_DEFS_SVH
`define DECODER_DEFS_SVH

// Widths fixed by the ISA
`define XLEN        64
`define ILEN        32
`define REG_IDX_W   5

//##########################################################################
// Major opcodes in inst[6:0]
`define OPC_LUI        7'b0110111
`define OPC_AUIPC      7'b0010111
`define OPC_JAL        7'b1101111
`define OPC_JALR       7'b1100111
`define OPC_BRANCH     7'b1100011
`define OPC_LOAD       7'b0000011
`define OPC_STORE      7'b0100011
`define OPC_OP_IMM     7'b0010011
`define OPC_OP         7'b0110011
`define OPC_OP_IMM_32  7'b0011011
`define OPC_OP_32      7'b0111011

//##########################################################################
// One-hot bit positions
`define IS_ADD      0
`define IS_SUB      1
`define IS_SLL      2
`define IS_SLT      3   // Also SLTU with is_unsigned set
`define IS_XOR      4
`define IS_SRL      5
`define IS_SRA      6
`define IS_OR       7
`define IS_AND      8
`define IS_LUI      9
`define IS_AUIPC    10
`define ALU_TYPE_W  11

`define IS_JAL      0
`define IS_JALR     1
`define IS_BEQ      2
`define IS_BNE      3
`define IS_BLT      4
`define IS_BGE      5
`define CX_TYPE_W   6

`define IS_B        0
`define IS_H        1
`define IS_W        2
`define IS_D        3
`define LS_SIZE_W   4

`endif
